// File: common/corePkg.sv
// Core architecture constants, opcodes, instruction word formats and pipeline structs
package corePkg;

  // Datapath and register index widths
  localparam int archBits = 32;
  localparam int regIdxBits = 5;
  localparam int opcodeBits = 7;

  // Multiplier depth in cycles from the execute register to the write port
  localparam int mulNumStages = 4;

  // First fetch address
  localparam logic [archBits-1:0] pcReset = 32'h00001000;
  // Bubble word, decodes as opNop
  localparam logic [archBits-1:0] nopInstruction = 32'hffffffff;

  // Opcodes
  localparam logic [opcodeBits-1:0] opAdd = 7'h00;
  localparam logic [opcodeBits-1:0] opSub = 7'h01;
  localparam logic [opcodeBits-1:0] opMul = 7'h02;
  localparam logic [opcodeBits-1:0] opMov = 7'h14;
  localparam logic [opcodeBits-1:0] opMovi = 7'h15;
  localparam logic [opcodeBits-1:0] opBeq = 7'h30;
  localparam logic [opcodeBits-1:0] opJump = 7'h31;
  localparam logic [opcodeBits-1:0] opNop = 7'h7f;

  // One instruction word, three field layouts
  typedef union packed {
    // ADD, SUB, MUL
    struct packed {
      logic [opcodeBits-1:0] opcode;
      logic [regIdxBits-1:0] dst;
      logic [regIdxBits-1:0] src1;
      logic [regIdxBits-1:0] src2;
      logic [9:0] unused;
    } rView;
    // MOV, MOVI, JUMP
    struct packed {
      logic [opcodeBits-1:0] opcode;
      logic [regIdxBits-1:0] dst;
      logic [regIdxBits-1:0] src1;
      logic [14:0] imm;
    } iView;
    // BEQ, offset split around the source fields
    struct packed {
      logic [opcodeBits-1:0] opcode;
      logic [regIdxBits-1:0] offsetHi;
      logic [regIdxBits-1:0] src1;
      logic [regIdxBits-1:0] src2;
      logic [9:0] offsetLo;
    } bView;
  } instWord_t;

  // Register write port
  typedef struct packed {
    logic valid;
    logic [regIdxBits-1:0] regIdx;
    logic [archBits-1:0] data;
  } regWrite_t;

  // Decode to execute payload
  typedef struct packed {
    logic [opcodeBits-1:0] opcode;
    logic [regIdxBits-1:0] dst;
    logic [archBits-1:0] pc;
    logic [archBits-1:0] opA;
    logic [archBits-1:0] opB;
    logic srcEq;
  } execOp_t;

  // Destination held by one multiplier stage
  typedef struct packed {
    logic valid;
    logic [regIdxBits-1:0] dst;
  } mulSlot_t;

endpackage

// File: source/fetchStage.sv
// Program counter with redirect and stall hold, decode instruction and PC registers
module fetchStage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         stall,
  input  logic                         takeBranch,
  input  logic [corePkg::archBits-1:0] branchTarget,
  input  corePkg::instWord_t           instData,
  output logic [corePkg::archBits-1:0] instAddr,
  output corePkg::instWord_t           decInst,
  output logic [corePkg::archBits-1:0] decPc
);

  logic [corePkg::archBits-1:0] pc;
  logic [corePkg::archBits-1:0] pcNext;

  // Redirect wins over stall
  always_comb
  begin
    if (takeBranch)
    begin
      pcNext = branchTarget;
    end
    else if (stall)
    begin
      pcNext = pc;
    end
    else
    begin
      pcNext = pc + 32'd4;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc <= corePkg::pcReset;
      decInst <= corePkg::nopInstruction;
    end
    else
    begin
      pc <= pcNext;
      // Word fetched in the branch shadow becomes a bubble
      if (takeBranch)
      begin
        decInst <= corePkg::nopInstruction;
      end
      else if (!stall)
      begin
        decInst <= instData;
      end
    end
  end

  // PC travels with the word into decode
  always_ff @(posedge clk)
  begin
    if (!stall || takeBranch)
    begin
      decPc <= pc;
    end
  end

  assign instAddr = pc;

endmodule

// File: source/decodeStage.sv
// Instruction decode, operand and immediate selection, execute and multiplier registers
module decodeStage (
  input  logic                           clk,
  input  logic                           rst,
  input  corePkg::instWord_t             decInst,
  input  logic [corePkg::archBits-1:0]   decPc,
  input  logic                           stall,
  input  logic                           takeBranch,
  input  logic [corePkg::archBits-1:0]   rdData1,
  input  logic [corePkg::archBits-1:0]   rdData2,
  input  logic                           bypass1,
  input  logic                           bypass2,
  input  logic [corePkg::archBits-1:0]   bypassData,
  output logic [corePkg::regIdxBits-1:0] rdIdx1,
  output logic [corePkg::regIdxBits-1:0] rdIdx2,
  output logic [1:0]                     srcUse,
  output corePkg::mulSlot_t              decDst,
  output corePkg::execOp_t               execOp,
  output corePkg::execOp_t               mulOp
);

  logic [corePkg::opcodeBits-1:0] opcode;
  logic isRType;
  logic isMul;
  logic kill;
  logic [corePkg::archBits-1:0] data1;
  logic [corePkg::archBits-1:0] data2;
  logic [corePkg::archBits-1:0] immSext;
  logic [corePkg::archBits-1:0] immZext;
  logic [corePkg::archBits-1:0] offsetSext;
  corePkg::execOp_t nextOp;

  // Opcode and source fields sit at the same bits in every view
  assign opcode = decInst.rView.opcode;
  assign rdIdx1 = decInst.rView.src1;
  assign rdIdx2 = decInst.rView.src2;

  assign isMul = (opcode == corePkg::opMul);
  assign isRType = (opcode == corePkg::opAdd) || (opcode == corePkg::opSub) || isMul;

  // Bit 0 src1, bit 1 src2
  assign srcUse[0] = isRType || (opcode == corePkg::opMov) ||
                     (opcode == corePkg::opBeq) || (opcode == corePkg::opJump);
  assign srcUse[1] = isRType || (opcode == corePkg::opBeq);

  // Destination only for register writers
  assign decDst.valid = isRType || (opcode == corePkg::opMov) || (opcode == corePkg::opMovi);
  assign decDst.dst = decInst.rView.dst;

  // ALU result first, then register file
  assign data1 = bypass1 ? bypassData : rdData1;
  assign data2 = bypass2 ? bypassData : rdData2;

  assign immSext = {{(corePkg::archBits-15){decInst.iView.imm[14]}}, decInst.iView.imm};
  assign immZext = {{(corePkg::archBits-15){1'b0}}, decInst.iView.imm};
  // BEQ offset is offsetHi above offsetLo
  assign offsetSext = {{(corePkg::archBits-15){decInst.bView.offsetHi[4]}},
                       decInst.bView.offsetHi, decInst.bView.offsetLo};

  always_comb
  begin
    nextOp.opcode = opcode;
    nextOp.dst = decInst.iView.dst;
    nextOp.pc = decPc;
    nextOp.opA = data1;
    nextOp.opB = data2;
    nextOp.srcEq = (data1 == data2);
    case (opcode)
      corePkg::opMov:
      begin
        nextOp.opB = '0;
      end
      corePkg::opMovi:
      begin
        nextOp.opA = immZext;
        nextOp.opB = '0;
      end
      // Target is pc plus offset
      corePkg::opBeq:
      begin
        nextOp.opA = decPc;
        nextOp.opB = offsetSext;
      end
      // Target is src1 plus imm
      corePkg::opJump:
      begin
        nextOp.opB = immSext;
      end
      default:
      begin
        nextOp.opB = data2;
      end
    endcase
  end

  // Bubble on hazard stall or on a redirect from the ALU
  assign kill = stall || takeBranch;

  always_ff @(posedge clk)
  begin
    execOp <= nextOp;
    mulOp <= nextOp;
    if (rst)
    begin
      execOp.opcode <= corePkg::opNop;
      mulOp.opcode <= corePkg::opNop;
    end
    else
    begin
      // MUL goes only to the multiplier, everything else only to the ALU
      execOp.opcode <= (kill || isMul) ? corePkg::opNop : opcode;
      mulOp.opcode <= (!kill && isMul) ? corePkg::opMul : corePkg::opNop;
    end
  end

endmodule

// File: source/registerFile.sv
// Integer register file with two read ports and two write-through write ports
module registerFile (
  input  logic                           clk,
  input  logic [corePkg::regIdxBits-1:0] rdIdx1,
  input  logic [corePkg::regIdxBits-1:0] rdIdx2,
  input  corePkg::regWrite_t             aluWrite,
  input  corePkg::regWrite_t             multWrite,
  output logic [corePkg::archBits-1:0]   rdData1,
  output logic [corePkg::archBits-1:0]   rdData2
);

  logic [corePkg::archBits-1:0] regs [2**corePkg::regIdxBits];

  // Same-cycle write returns the new value, ALU port last
  function automatic logic [corePkg::archBits-1:0] readThrough(
    input logic [corePkg::regIdxBits-1:0] idx,
    input logic [corePkg::archBits-1:0]   stored,
    input corePkg::regWrite_t             aluW,
    input corePkg::regWrite_t             multW
  );
    logic [corePkg::archBits-1:0] value;
    value = stored;
    if (multW.valid && (multW.regIdx == idx))
    begin
      value = multW.data;
    end
    if (aluW.valid && (aluW.regIdx == idx))
    begin
      value = aluW.data;
    end
    return value;
  endfunction

  assign rdData1 = readThrough(rdIdx1, regs[rdIdx1], aluWrite, multWrite);
  assign rdData2 = readThrough(rdIdx2, regs[rdIdx2], aluWrite, multWrite);

  // Hazard unit keeps the two ports off the same register
  always_ff @(posedge clk)
  begin
    if (multWrite.valid)
    begin
      regs[multWrite.regIdx] <= multWrite.data;
    end
    if (aluWrite.valid)
    begin
      regs[aluWrite.regIdx] <= aluWrite.data;
    end
  end

endmodule

// File: source/hazardUnit.sv
// Multiplier dependency stall and ALU result bypass for the decode stage
module hazardUnit (
  input  logic [corePkg::regIdxBits-1:0]                 rdIdx1,
  input  logic [corePkg::regIdxBits-1:0]                 rdIdx2,
  input  logic [1:0]                                     srcUse,
  input  corePkg::mulSlot_t                              decDst,
  input  corePkg::regWrite_t                             aluWrite,
  input  corePkg::mulSlot_t [corePkg::mulNumStages-1:0]  mulSlots,
  output logic                                           bypass1,
  output logic                                           bypass2,
  output logic [corePkg::archBits-1:0]                   bypassData,
  output logic                                           stall
);

  // Any MUL still short of its write port blocks decode
  always_comb
  begin
    stall = 1'b0;
    for (int i = 0; i < corePkg::mulNumStages; i++)
    begin
      if (mulSlots[i].valid)
      begin
        // Read after write on a used source
        stall = stall || (srcUse[0] && (mulSlots[i].dst == rdIdx1));
        stall = stall || (srcUse[1] && (mulSlots[i].dst == rdIdx2));
        // Write after write, the younger write would land first
        stall = stall || (decDst.valid && (decDst.dst == mulSlots[i].dst));
      end
    end
  end

  // Result leaving the ALU this cycle
  assign bypass1 = srcUse[0] && aluWrite.valid && (aluWrite.regIdx == rdIdx1);
  assign bypass2 = srcUse[1] && aluWrite.valid && (aluWrite.regIdx == rdIdx2);
  assign bypassData = aluWrite.data;

endmodule

// File: source/aluStage.sv
// Single-cycle ALU, branch resolution and the ALU register write port
module aluStage (
  input  corePkg::execOp_t             execOp,
  output corePkg::regWrite_t           aluWrite,
  output logic                         takeBranch,
  output logic [corePkg::archBits-1:0] branchTarget
);

  logic [corePkg::archBits-1:0] sum;
  logic [corePkg::archBits-1:0] result;
  logic writesReg;

  // Shared adder for ADD, MOV, MOVI and both branch targets
  assign sum = execOp.opA + execOp.opB;

  always_comb
  begin
    case (execOp.opcode)
      corePkg::opSub:
      begin
        result = execOp.opA - execOp.opB;
      end
      // opB is zero for the moves
      corePkg::opMov, corePkg::opMovi:
      begin
        result = execOp.opA;
      end
      default:
      begin
        result = sum;
      end
    endcase
  end

  assign writesReg = (execOp.opcode == corePkg::opAdd) ||
                     (execOp.opcode == corePkg::opSub) ||
                     (execOp.opcode == corePkg::opMov) ||
                     (execOp.opcode == corePkg::opMovi);

  assign aluWrite.valid = writesReg;
  assign aluWrite.regIdx = execOp.dst;
  assign aluWrite.data = result;

  // JUMP always, BEQ on the equality seen in decode
  assign takeBranch = (execOp.opcode == corePkg::opJump) ||
                      ((execOp.opcode == corePkg::opBeq) && execOp.srcEq);
  assign branchTarget = sum;

endmodule

// File: multiplier/multiplier.sv
// Four-stage pipelined multiplier with destination tracking for every stage
module multiplier (
  input  logic                                          clk,
  input  logic                                          rst,
  input  corePkg::execOp_t                              mulOp,
  output corePkg::regWrite_t                            multWrite,
  output corePkg::mulSlot_t [corePkg::mulNumStages-1:0] mulSlots
);

  corePkg::mulSlot_t entrySlot;
  corePkg::mulSlot_t [corePkg::mulNumStages-1:1] pipeSlot;
  corePkg::mulSlot_t doneSlot;
  // Partials against the low and high half of opB
  logic [corePkg::archBits+15:0] partLo;
  logic [corePkg::archBits+15:0] partHi;
  logic [2*corePkg::archBits-1:0] product;
  logic [2*corePkg::archBits-1:0] productHold;
  logic [corePkg::archBits-1:0] resultLo;

  // Stage 0 is the execute register itself
  assign entrySlot.valid = (mulOp.opcode == corePkg::opMul);
  assign entrySlot.dst = mulOp.dst;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pipeSlot <= '0;
      doneSlot <= '0;
    end
    else
    begin
      pipeSlot[1] <= entrySlot;
      for (int i = 2; i < corePkg::mulNumStages; i++)
      begin
        pipeSlot[i] <= pipeSlot[i-1];
      end
      doneSlot <= pipeSlot[corePkg::mulNumStages-1];
    end
  end

  // Product data moves alongside the slots
  always_ff @(posedge clk)
  begin
    partLo <= mulOp.opA * mulOp.opB[15:0];
    partHi <= mulOp.opA * mulOp.opB[31:16];
    product <= {16'b0, partLo} + {partHi, 16'b0};
    productHold <= product;
    // High word is dropped
    resultLo <= productHold[corePkg::archBits-1:0];
  end

  assign mulSlots = {pipeSlot, entrySlot};

  assign multWrite.valid = doneSlot.valid;
  assign multWrite.regIdx = doneSlot.dst;
  assign multWrite.data = resultLo;

endmodule

// File: source/coreTop.sv
// Core top level connecting fetch, decode, register file, hazard unit, ALU and multiplier
module coreTop (
  input  logic                         clk,
  input  logic                         rst,
  input  corePkg::instWord_t           instData,
  output logic [corePkg::archBits-1:0] instAddr,
  output corePkg::regWrite_t           aluWrite,
  output corePkg::regWrite_t           multWrite
);

  // Fetch to decode
  corePkg::instWord_t decInst;
  logic [corePkg::archBits-1:0] decPc;

  // Decode to execute
  corePkg::execOp_t execOp;
  corePkg::execOp_t mulOp;

  // Register reads and hazard inputs
  logic [corePkg::regIdxBits-1:0] rdIdx1;
  logic [corePkg::regIdxBits-1:0] rdIdx2;
  logic [corePkg::archBits-1:0] rdData1;
  logic [corePkg::archBits-1:0] rdData2;
  logic [1:0] srcUse;
  corePkg::mulSlot_t decDst;
  corePkg::mulSlot_t [corePkg::mulNumStages-1:0] mulSlots;

  // Hazard results
  logic stall;
  logic bypass1;
  logic bypass2;
  logic [corePkg::archBits-1:0] bypassData;

  // ALU redirect
  logic takeBranch;
  logic [corePkg::archBits-1:0] branchTarget;

  fetchStage fetch_i (.clk, .rst, .stall, .takeBranch, .branchTarget, .instData,
                      .instAddr, .decInst, .decPc);

  decodeStage decode_i (.clk, .rst, .decInst, .decPc, .stall, .takeBranch,
                        .rdData1, .rdData2, .bypass1, .bypass2, .bypassData,
                        .rdIdx1, .rdIdx2, .srcUse, .decDst, .execOp, .mulOp);

  registerFile regFile_i (.clk, .rdIdx1, .rdIdx2, .aluWrite, .multWrite, .rdData1, .rdData2);

  hazardUnit hazard_i (.rdIdx1, .rdIdx2, .srcUse, .decDst, .aluWrite, .mulSlots,
                       .bypass1, .bypass2, .bypassData, .stall);

  aluStage alu_i (.execOp, .aluWrite, .takeBranch, .branchTarget);

  multiplier mult_i (.clk, .rst, .mulOp, .multWrite, .mulSlots);

endmodule

// File: dv/coreAssertions.sv
// Bound checks on write values, write ordering, MUL latency, branch shadows and reset state
module coreAssertions (
  input logic                                          clk,
  input logic                                          rst,
  input logic [corePkg::archBits-1:0]                  instAddr,
  input corePkg::regWrite_t                            aluWrite,
  input corePkg::regWrite_t                            multWrite,
  input corePkg::instWord_t                            decInst,
  input logic                                          stall,
  input logic                                          takeBranch,
  input corePkg::mulSlot_t [corePkg::mulNumStages-1:0] mulSlots
);

  // True when some multiplier stage still owes a write to idx
  function automatic logic mulPending(
    input logic [corePkg::regIdxBits-1:0]                idx,
    input corePkg::mulSlot_t [corePkg::mulNumStages-1:0] slots
  );
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < corePkg::mulNumStages; i++)
    begin
      hit = hit || (slots[i].valid && (slots[i].dst == idx));
    end
    return hit;
  endfunction

  // ALU port against the table
  aluValue: assert property (@(posedge clk) disable iff (rst)
    aluWrite.valid |-> coreTb.aluExpSet[aluWrite.regIdx] &&
                       (aluWrite.data == coreTb.aluExp[aluWrite.regIdx]))
  else
  begin
    coreTb.errorCount++;
    $error("MISMATCH aluResult r%0d expected %h actual %h", $sampled(aluWrite.regIdx),
           coreTb.aluExp[$sampled(aluWrite.regIdx)], $sampled(aluWrite.data));
  end

  // Multiplier port, low product word
  mulValue: assert property (@(posedge clk) disable iff (rst)
    multWrite.valid |-> coreTb.mulExpSet[multWrite.regIdx] &&
                        (multWrite.data == coreTb.mulExp[multWrite.regIdx]))
  else
  begin
    coreTb.errorCount++;
    $error("MISMATCH mulResult r%0d expected %h actual %h", $sampled(multWrite.regIdx),
           coreTb.mulExp[$sampled(multWrite.regIdx)], $sampled(multWrite.data));
  end

  // Unstalled MUL leaves decode, result lands mulNumStages cycles after execute
  mulLatency: assert property (@(posedge clk) disable iff (rst)
    (decInst.rView.opcode == corePkg::opMul) && !stall && !takeBranch
      |-> ##(corePkg::mulNumStages + 1)
      (multWrite.valid &&
       (multWrite.regIdx == $past(decInst.rView.dst, corePkg::mulNumStages + 1))))
  else
  begin
    coreTb.errorCount++;
    $error("MUL result did not arrive on the multiplier port at the expected cycle");
  end

  // Younger ALU write must not overtake an older MUL
  wawOrder: assert property (@(posedge clk) disable iff (rst)
    aluWrite.valid |-> !mulPending(aluWrite.regIdx, mulSlots))
  else
  begin
    coreTb.errorCount++;
    $error("ALU wrote a register while an older MUL to it was still in flight");
  end

  // Nothing from a nullified slot
  shadowAlu: assert property (@(posedge clk) disable iff (rst)
    aluWrite.valid |-> !coreTb.poison[aluWrite.regIdx])
  else
  begin
    coreTb.errorCount++;
    $error("Instruction in a branch shadow wrote r%0d", $sampled(aluWrite.regIdx));
  end

  shadowMul: assert property (@(posedge clk) disable iff (rst)
    multWrite.valid |-> !coreTb.poison[multWrite.regIdx])
  else
  begin
    coreTb.errorCount++;
    $error("Multiplier wrote r%0d from a branch shadow", $sampled(multWrite.regIdx));
  end

  // Reset cycles and the first cycle after
  resetAddr: assert property (@(posedge clk)
    rst |=> (instAddr == corePkg::pcReset))
  else
  begin
    coreTb.errorCount++;
    $error("MISMATCH resetAddr expected %h actual %h", corePkg::pcReset, $sampled(instAddr));
  end

  resetWrites: assert property (@(posedge clk)
    rst |=> (!aluWrite.valid && !multWrite.valid))
  else
  begin
    coreTb.errorCount++;
    $error("A write port was valid during or right after reset");
  end

endmodule

// File: dv/coreTb.sv
// Testbench with clock, reset, program ROM, expected-register tables, watchdog and report
module coreTb;

  // Program shape and run limits
  localparam int progLen = 28;
  localparam int endSlot = progLen + corePkg::mulNumStages + 2;
  localparam int timeoutCycles = progLen * (corePkg::mulNumStages + 4) + 8 + 50;

  logic clk;
  logic rst;
  corePkg::instWord_t instData;
  logic [corePkg::archBits-1:0] instAddr;
  corePkg::regWrite_t aluWrite;
  corePkg::regWrite_t multWrite;

  corePkg::instWord_t rom [progLen];
  // Architectural model plus the value each port should deliver per register
  logic [31:0] model [32];
  logic [31:0] aluExp [32];
  logic [31:0] mulExp [32];
  logic aluExpSet [32];
  logic mulExpSet [32];
  logic poison [32];

  int errorCount;
  int aluWrites;
  int mulWrites;
  int aluExpected;
  int mulExpected;
  int emitIdx;
  integer seed;

  coreTop dut_i (.clk, .rst, .instData, .instAddr, .aluWrite, .multWrite);

  bind coreTop coreAssertions assertions_i (.clk, .rst, .instAddr, .aluWrite, .multWrite,
                                            .decInst, .stall, .takeBranch, .mulSlots);

  always
  begin
    #5 clk = ~clk;
  end

  function automatic corePkg::instWord_t rWord(input logic [6:0] op, input logic [4:0] dst,
                                               input logic [4:0] s1, input logic [4:0] s2);
    corePkg::instWord_t w;
    w.rView.opcode = op;
    w.rView.dst = dst;
    w.rView.src1 = s1;
    w.rView.src2 = s2;
    w.rView.unused = '0;
    return w;
  endfunction

  function automatic corePkg::instWord_t iWord(input logic [6:0] op, input logic [4:0] dst,
                                               input logic [4:0] s1, input logic [14:0] imm);
    corePkg::instWord_t w;
    w.iView.opcode = op;
    w.iView.dst = dst;
    w.iView.src1 = s1;
    w.iView.imm = imm;
    return w;
  endfunction

  // Offset split across the dst and low fields
  function automatic corePkg::instWord_t bWord(input logic [4:0] s1, input logic [4:0] s2,
                                               input logic [14:0] offset);
    corePkg::instWord_t w;
    w.bView.opcode = corePkg::opBeq;
    w.bView.offsetHi = offset[14:10];
    w.bView.src1 = s1;
    w.bView.src2 = s2;
    w.bView.offsetLo = offset[9:0];
    return w;
  endfunction

  // Word at a fetch address, bubbles outside the program
  function automatic corePkg::instWord_t romWord(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - corePkg::pcReset;
    if ((offset[1:0] == 2'b00) && ((offset >> 2) < progLen))
    begin
      return rom[offset >> 2];
    end
    return corePkg::nopInstruction;
  endfunction

  // Immediate field from the seeded random stream
  function automatic logic [14:0] randomImm();
    logic [31:0] r;
    r = $random(seed);
    return r[14:0];
  endfunction

  task automatic emit(input corePkg::instWord_t w);
    rom[emitIdx] = w;
    emitIdx++;
  endtask

  task automatic expectAlu(input logic [4:0] dst);
    aluExp[dst] = model[dst];
    aluExpSet[dst] = 1'b1;
    aluExpected++;
  endtask

  task automatic putMovi(input logic [4:0] dst, input logic [14:0] imm);
    emit(iWord(corePkg::opMovi, dst, 5'd0, imm));
    model[dst] = {17'b0, imm};
    expectAlu(dst);
  endtask

  task automatic putMov(input logic [4:0] dst, input logic [4:0] s1);
    emit(iWord(corePkg::opMov, dst, s1, 15'd0));
    model[dst] = model[s1];
    expectAlu(dst);
  endtask

  // ADD or SUB, 32-bit wrap
  task automatic putAlu(input logic [6:0] op, input logic [4:0] dst,
                        input logic [4:0] s1, input logic [4:0] s2);
    emit(rWord(op, dst, s1, s2));
    model[dst] = (op == corePkg::opSub) ? model[s1] - model[s2] : model[s1] + model[s2];
    expectAlu(dst);
  endtask

  task automatic putMul(input logic [4:0] dst, input logic [4:0] s1, input logic [4:0] s2);
    logic [63:0] product;
    emit(rWord(corePkg::opMul, dst, s1, s2));
    product = {32'b0, model[s1]} * {32'b0, model[s2]};
    model[dst] = product[31:0];
    mulExp[dst] = product[31:0];
    mulExpSet[dst] = 1'b1;
    mulExpected++;
  endtask

  // Slot that a taken branch must nullify
  task automatic putShadow(input logic [4:0] dst);
    emit(iWord(corePkg::opMovi, dst, 5'd0, 15'h2a5a));
    poison[dst] = 1'b1;
  endtask

  // MUL in the slot that sits in decode when the branch resolves
  task automatic putMulShadow(input logic [4:0] dst);
    emit(rWord(corePkg::opMul, dst, 5'd1, 5'd2));
    poison[dst] = 1'b1;
  endtask

  // Absolute target through a zero base register
  task automatic putJump(input logic [4:0] base, input int targetIdx);
    logic [31:0] target;
    target = corePkg::pcReset + 4 * targetIdx;
    emit(iWord(corePkg::opJump, 5'd0, base, target[14:0]));
  endtask

  task automatic buildProgram();
    putMovi(5'd1, randomImm());
    putMovi(5'd2, randomImm());
    putMovi(5'd3, randomImm());
    putMovi(5'd4, randomImm());
    // Odd, so r5 never equals r4
    putMovi(5'd6, randomImm() | 15'd1);
    putMovi(5'd30, 15'd0);
    // Back-to-back dependency through the bypass
    putAlu(corePkg::opAdd, 5'd7, 5'd1, 5'd2);
    putAlu(corePkg::opAdd, 5'd8, 5'd7, 5'd3);
    putAlu(corePkg::opSub, 5'd9, 5'd1, 5'd2);
    putMov(5'd17, 5'd9);
    // Read after MUL
    putMul(5'd10, 5'd1, 5'd2);
    putAlu(corePkg::opAdd, 5'd11, 5'd10, 5'd3);
    // Write after MUL
    putMul(5'd12, 5'd2, 5'd3);
    putMovi(5'd12, randomImm());
    // Two MULs in flight, then a wide product
    putMul(5'd13, 5'd1, 5'd3);
    putMul(5'd14, 5'd2, 5'd4);
    putAlu(corePkg::opAdd, 5'd15, 5'd13, 5'd14);
    putMul(5'd16, 5'd15, 5'd13);
    // Taken BEQ skips two
    emit(bWord(5'd1, 5'd1, 15'd12));
    putMulShadow(5'd20);
    putShadow(5'd21);
    putJump(5'd30, 24);
    putMulShadow(5'd22);
    putShadow(5'd23);
    putAlu(corePkg::opAdd, 5'd5, 5'd4, 5'd6);
    // Not taken, fall-through must write
    emit(bWord(5'd4, 5'd5, 15'd12));
    putMovi(5'd24, randomImm());
    putAlu(corePkg::opAdd, 5'd25, 5'd24, 5'd16);
  endtask

  // Fetch data for the current address, changed away from the rising edge
  always @(negedge clk)
  begin
    instData <= romWord(instAddr);
  end

  // Tally of write port activity
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (aluWrite.valid === 1'b1)
      begin
        aluWrites++;
      end
      if (multWrite.valid === 1'b1)
      begin
        mulWrites++;
      end
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    instData = corePkg::nopInstruction;
    errorCount = 0;
    aluWrites = 0;
    mulWrites = 0;
    aluExpected = 0;
    mulExpected = 0;
    emitIdx = 0;
    seed = 32'ha4fb9e08;
    for (int i = 0; i < 32; i++)
    begin
      model[i] = '0;
      aluExp[i] = '0;
      mulExp[i] = '0;
      aluExpSet[i] = 1'b0;
      mulExpSet[i] = 1'b0;
      poison[i] = 1'b0;
    end
    buildProgram();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    // Past the last instruction far enough for the pipes to drain
    while (instAddr !== corePkg::pcReset + 4 * endSlot)
    begin
      @(negedge clk);
    end
    if (aluWrites != aluExpected)
    begin
      errorCount++;
      $display("MISMATCH aluWriteCount expected %0d actual %0d", aluExpected, aluWrites);
    end
    if (mulWrites != mulExpected)
    begin
      errorCount++;
      $display("MISMATCH mulWriteCount expected %0d actual %0d", mulExpected, mulWrites);
    end
    $display("Errors: %0d", errorCount);
    if (errorCount == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(timeoutCycles * 10);
    errorCount++;
    $display("Program did not reach its end address within %0d cycles", timeoutCycles);
    $display("Errors: %0d", errorCount);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: coreTop.f
common/corePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/registerFile.sv
source/hazardUnit.sv
source/aluStage.sv
multiplier/multiplier.sv
source/coreTop.sv
dv/coreAssertions.sv
dv/coreTb.sv
